// ==== Bender.yml ====
package:
  name: stepper_cmd

sources:
  - include_dirs:
      - .
    files:
      - stepper_cmd_pkg.sv
      - cmd_decoder.sv
      - move_buffer.sv
      - driver_config_regs.sv
      - cos_table_regs.sv
      - stepper_cmd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_stepper_cmd.sv

// ==== cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder
  import stepper_cmd_pkg::*;
(
  input  logic                   word_received,
  input  logic                   rst_n,
  input  logic [63:0]            word_data_received,
  input  logic [63:0]            encoder_count,
  output logic [63:0]            word_send_data,
  output logic                   move_begin,
  output logic                   move_duration_wr,
  output logic                   move_increment_wr,
  output logic                   move_commit,
  output logic                   cfg_wr,
  output cmd_opcode_t            cfg_opcode,
  output logic                   cos_wr
);

  msg_state_t             state;
  logic [move_word_w-1:0] encoder_store;
  logic                   in_header;
  logic                   is_cfg;

  // Header byte as seen by the datapath
  assign cfg_opcode = cmd_opcode_t'(word_data_received[63:56]);
  assign in_header  = (state == msg_header);

  always_comb begin
    case (cfg_opcode)
      clk_divisor, motor_config, microstepper_config,
      chargepump, bridge_invert, motor_enable:
        is_cfg = 1'b1;
      default:
        is_cfg = 1'b0;
    endcase
  end

  // Strobes for the word currently on word_data_received
  assign move_begin        = in_header && (cfg_opcode == coordinated_step);
  assign cfg_wr            = in_header && is_cfg;
  assign cos_wr            = in_header && (cfg_opcode == cosine_config);
  assign move_duration_wr  = (state == msg_duration);
  assign move_increment_wr = (state == msg_increment);
  assign move_commit       = (state == msg_incinc);

  // Message position, only coordinated_step spans more than one word
  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      state <= msg_header;
    end else begin
      case (state)
        msg_header: begin
          if (move_begin) begin
            state <= msg_duration;
          end
        end
        msg_duration:  state <= msg_increment;
        msg_increment: state <= msg_incinc;
        default:       state <= msg_header;
      endcase
    end
  end

  // Encoder position at the start of a move, reported two words later
  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      encoder_store <= '0;
    end else if (move_begin) begin
      encoder_store <= encoder_count;
    end
  end

  // Reply for the next exchange, zero unless a command asks for data
  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      word_send_data <= '0;
    end else begin
      word_send_data <= '0;
      if (in_header && (cfg_opcode == api_version)) begin
        word_send_data[23:16] <= version_major;
        word_send_data[15:8]  <= version_minor;
        word_send_data[7:0]   <= version_patch;
      end else if (move_increment_wr) begin
        word_send_data <= encoder_store;
      end
    end
  end

endmodule

// ==== cos_table_init.svh ====
// Quarter-wave cosine starting at full scale for entry 0
localparam logic [7:0] cos_init_0 = 8'd255;
localparam logic [7:0] cos_init_1 = 8'd255;
localparam logic [7:0] cos_init_2 = 8'd255;
localparam logic [7:0] cos_init_3 = 8'd254;
localparam logic [7:0] cos_init_4 = 8'd254;
localparam logic [7:0] cos_init_5 = 8'd253;
localparam logic [7:0] cos_init_6 = 8'd252;
localparam logic [7:0] cos_init_7 = 8'd251;
localparam logic [7:0] cos_init_8 = 8'd250;
localparam logic [7:0] cos_init_9 = 8'd249;
localparam logic [7:0] cos_init_10 = 8'd247;
localparam logic [7:0] cos_init_11 = 8'd246;
localparam logic [7:0] cos_init_12 = 8'd244;
localparam logic [7:0] cos_init_13 = 8'd242;
localparam logic [7:0] cos_init_14 = 8'd240;
localparam logic [7:0] cos_init_15 = 8'd238;
localparam logic [7:0] cos_init_16 = 8'd236;
localparam logic [7:0] cos_init_17 = 8'd233;
localparam logic [7:0] cos_init_18 = 8'd231;
localparam logic [7:0] cos_init_19 = 8'd228;
localparam logic [7:0] cos_init_20 = 8'd225;
localparam logic [7:0] cos_init_21 = 8'd222;
localparam logic [7:0] cos_init_22 = 8'd219;
localparam logic [7:0] cos_init_23 = 8'd215;
localparam logic [7:0] cos_init_24 = 8'd212;
localparam logic [7:0] cos_init_25 = 8'd208;
localparam logic [7:0] cos_init_26 = 8'd205;
localparam logic [7:0] cos_init_27 = 8'd201;
localparam logic [7:0] cos_init_28 = 8'd197;
localparam logic [7:0] cos_init_29 = 8'd193;
localparam logic [7:0] cos_init_30 = 8'd189;
localparam logic [7:0] cos_init_31 = 8'd185;
localparam logic [7:0] cos_init_32 = 8'd180;
localparam logic [7:0] cos_init_33 = 8'd176;
localparam logic [7:0] cos_init_34 = 8'd171;
localparam logic [7:0] cos_init_35 = 8'd167;
localparam logic [7:0] cos_init_36 = 8'd162;
localparam logic [7:0] cos_init_37 = 8'd157;
localparam logic [7:0] cos_init_38 = 8'd152;
localparam logic [7:0] cos_init_39 = 8'd147;
localparam logic [7:0] cos_init_40 = 8'd142;
localparam logic [7:0] cos_init_41 = 8'd136;
localparam logic [7:0] cos_init_42 = 8'd131;
localparam logic [7:0] cos_init_43 = 8'd126;
localparam logic [7:0] cos_init_44 = 8'd120;
localparam logic [7:0] cos_init_45 = 8'd115;
localparam logic [7:0] cos_init_46 = 8'd109;
localparam logic [7:0] cos_init_47 = 8'd103;
localparam logic [7:0] cos_init_48 = 8'd98;
localparam logic [7:0] cos_init_49 = 8'd92;
localparam logic [7:0] cos_init_50 = 8'd86;
localparam logic [7:0] cos_init_51 = 8'd80;
localparam logic [7:0] cos_init_52 = 8'd74;
localparam logic [7:0] cos_init_53 = 8'd68;
localparam logic [7:0] cos_init_54 = 8'd62;
localparam logic [7:0] cos_init_55 = 8'd56;
localparam logic [7:0] cos_init_56 = 8'd50;
localparam logic [7:0] cos_init_57 = 8'd44;
localparam logic [7:0] cos_init_58 = 8'd37;
localparam logic [7:0] cos_init_59 = 8'd31;
localparam logic [7:0] cos_init_60 = 8'd25;
localparam logic [7:0] cos_init_61 = 8'd19;
localparam logic [7:0] cos_init_62 = 8'd13;
localparam logic [7:0] cos_init_63 = 8'd6;

// ==== cos_table_regs.sv ====
`timescale 1ns/1ps

module cos_table_regs (
  input  logic         word_received,
  input  logic         rst_n,
  input  logic [63:0]  word_data_received,
  input  logic         cos_wr,
  output logic [511:0] cos_table
);

  `include "cos_table_init.svh"

  // Entry n sits in bits 8n+7:8n
  localparam logic [511:0] cos_reset = {
    cos_init_63, cos_init_62, cos_init_61, cos_init_60,
    cos_init_59, cos_init_58, cos_init_57, cos_init_56,
    cos_init_55, cos_init_54, cos_init_53, cos_init_52,
    cos_init_51, cos_init_50, cos_init_49, cos_init_48,
    cos_init_47, cos_init_46, cos_init_45, cos_init_44,
    cos_init_43, cos_init_42, cos_init_41, cos_init_40,
    cos_init_39, cos_init_38, cos_init_37, cos_init_36,
    cos_init_35, cos_init_34, cos_init_33, cos_init_32,
    cos_init_31, cos_init_30, cos_init_29, cos_init_28,
    cos_init_27, cos_init_26, cos_init_25, cos_init_24,
    cos_init_23, cos_init_22, cos_init_21, cos_init_20,
    cos_init_19, cos_init_18, cos_init_17, cos_init_16,
    cos_init_15, cos_init_14, cos_init_13, cos_init_12,
    cos_init_11, cos_init_10, cos_init_9,  cos_init_8,
    cos_init_7,  cos_init_6,  cos_init_5,  cos_init_4,
    cos_init_3,  cos_init_2,  cos_init_1,  cos_init_0
  };

  // Group of four entries, byte k of the payload goes to entry 4*group+k
  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      cos_table <= cos_reset;
    end else if (cos_wr) begin
      cos_table[{word_data_received[35:32], 5'b0} +: 32] <= word_data_received[31:0];
    end
  end

endmodule

// ==== driver_config_regs.sv ====
`timescale 1ns/1ps

module driver_config_regs
  import stepper_cmd_pkg::*;
(
  input  logic        word_received,
  input  logic        rst_n,
  input  logic [63:0] word_data_received,
  input  logic        cfg_wr,
  input  cmd_opcode_t cfg_opcode,
  output logic        enable,
  output logic [7:0]  clock_divisor,
  output logic [2:0]  microsteps,
  output logic [7:0]  current,
  output logic [9:0]  config_offtime,
  output logic [7:0]  config_blanktime,
  output logic [9:0]  config_fastdecay_threshold,
  output logic [7:0]  config_minimum_on_time,
  output logic [10:0] config_current_threshold,
  output logic [7:0]  config_chargepump_period,
  output logic        config_invert_highside,
  output logic        config_invert_lowside
);

  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      enable                     <= 1'b0;
      clock_divisor              <= 8'd40;
      microsteps                 <= 3'd2;
      current                    <= 8'd140;
      config_offtime             <= 10'd810;
      config_blanktime           <= 8'd27;
      config_fastdecay_threshold <= 10'd706;
      config_minimum_on_time     <= 8'd54;
      config_current_threshold   <= 11'd1024;
      config_chargepump_period   <= 8'd91;
      config_invert_highside     <= 1'b1;
      config_invert_lowside      <= 1'b1;
    end else if (cfg_wr) begin
      case (cfg_opcode)
        motor_enable: enable <= word_data_received[0];
        clk_divisor:  clock_divisor <= word_data_received[7:0];
        chargepump:   config_chargepump_period <= word_data_received[7:0];
        motor_config: begin
          current    <= word_data_received[15:8];
          microsteps <= word_data_received[2:0];
        end
        // Chopper timing for the bridge driver
        microstepper_config: begin
          config_offtime             <= word_data_received[49:40];
          config_blanktime           <= word_data_received[39:32];
          config_fastdecay_threshold <= word_data_received[29:20];
          config_minimum_on_time     <= word_data_received[17:10];
          config_current_threshold   <= word_data_received[10:0];
        end
        bridge_invert: begin
          config_invert_highside <= word_data_received[1];
          config_invert_lowside  <= word_data_received[0];
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== move_buffer.sv ====
`timescale 1ns/1ps

module move_buffer #(
  parameter int MOVE_BUFFER_SIZE = 4,
  parameter int IDX_W = (MOVE_BUFFER_SIZE > 1) ? $clog2(MOVE_BUFFER_SIZE) : 1
) (
  input  logic                        word_received,
  input  logic                        rst_n,
  input  logic [63:0]                 word_data_received,
  input  logic                        move_begin,
  input  logic                        move_duration_wr,
  input  logic                        move_increment_wr,
  input  logic                        move_commit,
  input  logic [IDX_W-1:0]            read_index,
  input  logic [MOVE_BUFFER_SIZE-1:0] slot_finished,
  output logic [MOVE_BUFFER_SIZE-1:0] slot_ready,
  output logic                        buffer_space,
  output logic                        dir,
  output logic [63:0]                 move_duration,
  output logic [63:0]                 increment,
  output logic [63:0]                 incrementincrement
);

  logic [IDX_W-1:0]            wr_idx;
  logic [MOVE_BUFFER_SIZE-1:0] pending;
  logic [MOVE_BUFFER_SIZE-1:0] dir_mem;
  logic [63:0]                 duration_mem [MOVE_BUFFER_SIZE];
  logic [63:0]                 increment_mem [MOVE_BUFFER_SIZE];
  logic [63:0]                 incinc_mem [MOVE_BUFFER_SIZE];

  // A slot is busy while its two toggles disagree
  assign pending      = slot_ready ^ slot_finished;
  assign buffer_space = ~&pending;

  // Record fields land in the slot at the write index
  always_ff @(posedge word_received) begin
    if (move_begin) begin
      dir_mem[wr_idx] <= word_data_received[0];
    end
    if (move_duration_wr) begin
      duration_mem[wr_idx] <= word_data_received;
    end
    if (move_increment_wr) begin
      increment_mem[wr_idx] <= word_data_received;
    end
    if (move_commit) begin
      incinc_mem[wr_idx] <= word_data_received;
    end
  end

  // Hand the slot over on commit, drop the move if it is still busy
  always_ff @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx     <= '0;
      slot_ready <= '0;
    end else if (move_commit && !pending[wr_idx]) begin
      slot_ready[wr_idx] <= ~slot_ready[wr_idx];
      wr_idx <= (wr_idx == IDX_W'(MOVE_BUFFER_SIZE - 1)) ? '0 : wr_idx + 1'b1;
    end
  end

  assign dir                = dir_mem[read_index];
  assign move_duration      = duration_mem[read_index];
  assign increment          = increment_mem[read_index];
  assign incrementincrement = incinc_mem[read_index];

endmodule

// ==== project.f ====
+incdir+.
stepper_cmd_pkg.sv
cmd_decoder.sv
move_buffer.sv
driver_config_regs.sv
cos_table_regs.sv
stepper_cmd_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_stepper_cmd.sv

// ==== stepper_cmd_pkg.sv ====
package stepper_cmd_pkg;

  // Width of one host word and of every move field
  localparam int move_word_w = 64;

  // Reported by the api_version command
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd0;

  // Header byte of a command word, bits 63:56
  typedef enum logic [7:0] {
    coordinated_step    = 8'h01,
    clk_divisor         = 8'h03,
    motor_config        = 8'h04,
    microstepper_config = 8'h05,
    chargepump          = 8'h06,
    bridge_invert       = 8'h07,
    cosine_config       = 8'h08,
    motor_enable        = 8'h0A,
    api_version         = 8'hFE
  } cmd_opcode_t;

  // Position inside a coordinated_step message
  typedef enum logic [1:0] {
    msg_header,
    msg_duration,
    msg_increment,
    msg_incinc
  } msg_state_t;

endpackage

// ==== stepper_cmd_top.sv ====
`timescale 1ns/1ps

module stepper_cmd_top
  import stepper_cmd_pkg::*;
#(
  parameter int MOVE_BUFFER_SIZE = 4,
  parameter int IDX_W = (MOVE_BUFFER_SIZE > 1) ? $clog2(MOVE_BUFFER_SIZE) : 1
) (
  input  logic                        word_received,
  input  logic                        rst_n,
  input  logic [63:0]                 word_data_received,
  input  logic [63:0]                 encoder_count,
  output logic [63:0]                 word_send_data,
  // Execution side of the move buffer
  input  logic [IDX_W-1:0]            read_index,
  input  logic [MOVE_BUFFER_SIZE-1:0] slot_finished,
  output logic [MOVE_BUFFER_SIZE-1:0] slot_ready,
  output logic                        buffer_space,
  output logic                        dir,
  output logic [63:0]                 move_duration,
  output logic [63:0]                 increment,
  output logic [63:0]                 incrementincrement,
  // Driver configuration
  output logic                        enable,
  output logic [7:0]                  clock_divisor,
  output logic [2:0]                  microsteps,
  output logic [7:0]                  current,
  output logic [9:0]                  config_offtime,
  output logic [7:0]                  config_blanktime,
  output logic [9:0]                  config_fastdecay_threshold,
  output logic [7:0]                  config_minimum_on_time,
  output logic [10:0]                 config_current_threshold,
  output logic [7:0]                  config_chargepump_period,
  output logic                        config_invert_highside,
  output logic                        config_invert_lowside,
  output logic [511:0]                cos_table
);

  logic        move_begin;
  logic        move_duration_wr;
  logic        move_increment_wr;
  logic        move_commit;
  logic        cfg_wr;
  cmd_opcode_t cfg_opcode;
  logic        cos_wr;

  cmd_decoder u_decoder (
    .word_received, .rst_n, .word_data_received, .encoder_count, .word_send_data,
    .move_begin, .move_duration_wr, .move_increment_wr, .move_commit,
    .cfg_wr, .cfg_opcode, .cos_wr
  );

  move_buffer #(
    .MOVE_BUFFER_SIZE(MOVE_BUFFER_SIZE),
    .IDX_W(IDX_W)
  ) u_move_buffer (
    .word_received, .rst_n, .word_data_received,
    .move_begin, .move_duration_wr, .move_increment_wr, .move_commit,
    .read_index, .slot_finished, .slot_ready, .buffer_space,
    .dir, .move_duration, .increment, .incrementincrement
  );

  driver_config_regs u_config (
    .word_received, .rst_n, .word_data_received, .cfg_wr, .cfg_opcode,
    .enable, .clock_divisor, .microsteps, .current,
    .config_offtime, .config_blanktime, .config_fastdecay_threshold,
    .config_minimum_on_time, .config_current_threshold,
    .config_chargepump_period, .config_invert_highside, .config_invert_lowside
  );

  cos_table_regs u_cos_table (
    .word_received, .rst_n, .word_data_received, .cos_wr, .cos_table
  );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
  import stepper_cmd_pkg::*;
#(
  parameter int buf_size = 4,
  parameter int idx_w = 2
) (
  input  logic                word_received,
  input  logic                rst_n,
  input  logic [63:0]         word_data_received,
  input  logic [63:0]         encoder_count,
  input  logic [idx_w-1:0]    read_index,
  input  logic [buf_size-1:0] slot_finished,
  input  logic [63:0]         word_send_data,
  input  logic [buf_size-1:0] slot_ready,
  input  logic                buffer_space,
  input  logic                dir,
  input  logic [63:0]         move_duration,
  input  logic [63:0]         increment,
  input  logic [63:0]         incrementincrement,
  input  logic                enable,
  input  logic [7:0]          clock_divisor,
  input  logic [2:0]          microsteps,
  input  logic [7:0]          current,
  input  logic [9:0]          config_offtime,
  input  logic [7:0]          config_blanktime,
  input  logic [9:0]          config_fastdecay_threshold,
  input  logic [7:0]          config_minimum_on_time,
  input  logic [10:0]         config_current_threshold,
  input  logic [7:0]          config_chargepump_period,
  input  logic                config_invert_highside,
  input  logic                config_invert_lowside,
  input  logic [511:0]        cos_table,
  input  int                  test_num,
  input  logic                test_end,
  output int                  error_count,
  output int                  tests_run,
  output int                  tests_failed
);

  `include "cos_table_init.svh"

  // Entry n in bits 8n+7:8n
  localparam logic [511:0] cos_default = {
    cos_init_63, cos_init_62, cos_init_61, cos_init_60, cos_init_59, cos_init_58,
    cos_init_57, cos_init_56, cos_init_55, cos_init_54, cos_init_53, cos_init_52,
    cos_init_51, cos_init_50, cos_init_49, cos_init_48, cos_init_47, cos_init_46,
    cos_init_45, cos_init_44, cos_init_43, cos_init_42, cos_init_41, cos_init_40,
    cos_init_39, cos_init_38, cos_init_37, cos_init_36, cos_init_35, cos_init_34,
    cos_init_33, cos_init_32, cos_init_31, cos_init_30, cos_init_29, cos_init_28,
    cos_init_27, cos_init_26, cos_init_25, cos_init_24, cos_init_23, cos_init_22,
    cos_init_21, cos_init_20, cos_init_19, cos_init_18, cos_init_17, cos_init_16,
    cos_init_15, cos_init_14, cos_init_13, cos_init_12, cos_init_11, cos_init_10,
    cos_init_9,  cos_init_8,  cos_init_7,  cos_init_6,  cos_init_5,  cos_init_4,
    cos_init_3,  cos_init_2,  cos_init_1,  cos_init_0
  };

  // Expected driver configuration
  logic                exp_enable;
  logic [7:0]          exp_clock_divisor;
  logic [2:0]          exp_microsteps;
  logic [7:0]          exp_current;
  logic [9:0]          exp_offtime;
  logic [7:0]          exp_blanktime;
  logic [9:0]          exp_fastdecay;
  logic [7:0]          exp_min_on;
  logic [10:0]         exp_cur_thr;
  logic [7:0]          exp_chargepump;
  logic                exp_inv_high;
  logic                exp_inv_low;
  logic [511:0]        exp_cos;
  // Expected message position, reply and move slots
  msg_state_t          msg_pos;
  logic [63:0]         exp_snapshot;
  logic [63:0]         exp_reply;
  logic [buf_size-1:0] exp_ready;
  int                  exp_wr;
  logic                exp_dir [buf_size];
  logic [63:0]         exp_duration [buf_size];
  logic [63:0]         exp_increment [buf_size];
  logic [63:0]         exp_incinc [buf_size];
  int                  errors_in_test;

  task automatic reset_model();
    exp_enable = 1'b0;
    exp_clock_divisor = 8'd40;
    exp_microsteps = 3'd2;
    exp_current = 8'd140;
    exp_offtime = 10'd810;
    exp_blanktime = 8'd27;
    exp_fastdecay = 10'd706;
    exp_min_on = 8'd54;
    exp_cur_thr = 11'd1024;
    exp_chargepump = 8'd91;
    exp_inv_high = 1'b1;
    exp_inv_low = 1'b1;
    exp_cos = cos_default;
    msg_pos = msg_header;
    exp_snapshot = '0;
    exp_reply = '0;
    exp_ready = '0;
    exp_wr = 0;
  endtask

  task automatic apply_word(input logic [63:0] w, input logic [63:0] enc);
    logic [buf_size-1:0] busy;
    busy = exp_ready ^ slot_finished;
    exp_reply = '0;
    case (msg_pos)
      msg_header: begin
        case (w[63:56])
          coordinated_step: begin
            exp_dir[exp_wr] = w[0];
            exp_snapshot = enc;
            msg_pos = msg_duration;
          end
          clk_divisor: exp_clock_divisor = w[7:0];
          chargepump: exp_chargepump = w[7:0];
          motor_enable: exp_enable = w[0];
          motor_config: begin
            exp_current = w[15:8];
            exp_microsteps = w[2:0];
          end
          microstepper_config: begin
            exp_offtime = w[49:40];
            exp_blanktime = w[39:32];
            exp_fastdecay = w[29:20];
            exp_min_on = w[17:10];
            exp_cur_thr = w[10:0];
          end
          bridge_invert: begin
            exp_inv_high = w[1];
            exp_inv_low = w[0];
          end
          cosine_config: begin
            for (int k = 0; k < 4; k++) begin
              exp_cos[8 * (4 * w[35:32] + k) +: 8] = w[8 * k +: 8];
            end
          end
          api_version: exp_reply = {40'd0, version_major, version_minor, version_patch};
          default: ;
        endcase
      end
      msg_duration: begin
        exp_duration[exp_wr] = w;
        msg_pos = msg_increment;
      end
      msg_increment: begin
        exp_increment[exp_wr] = w;
        exp_reply = exp_snapshot;
        msg_pos = msg_incinc;
      end
      default: begin
        exp_incinc[exp_wr] = w;
        // A pending slot refuses the commit
        if (!busy[exp_wr]) begin
          exp_ready[exp_wr] = ~exp_ready[exp_wr];
          exp_wr = (exp_wr + 1) % buf_size;
        end
        msg_pos = msg_header;
      end
    endcase
  endtask

  task automatic compare_value(input string name, input logic [511:0] expected,
                               input logic [511:0] actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors_in_test++;
      error_count++;
    end
  endtask

  task automatic compare_outputs();
    logic [buf_size-1:0] busy;
    busy = exp_ready ^ slot_finished;
    compare_value("word_send_data", exp_reply, word_send_data);
    compare_value("slot_ready", exp_ready, slot_ready);
    compare_value("buffer_space", |(~busy), buffer_space);
    compare_value("enable", exp_enable, enable);
    compare_value("clock_divisor", exp_clock_divisor, clock_divisor);
    compare_value("microsteps", exp_microsteps, microsteps);
    compare_value("current", exp_current, current);
    compare_value("config_offtime", exp_offtime, config_offtime);
    compare_value("config_blanktime", exp_blanktime, config_blanktime);
    compare_value("config_fastdecay_threshold", exp_fastdecay, config_fastdecay_threshold);
    compare_value("config_minimum_on_time", exp_min_on, config_minimum_on_time);
    compare_value("config_current_threshold", exp_cur_thr, config_current_threshold);
    compare_value("config_chargepump_period", exp_chargepump, config_chargepump_period);
    compare_value("config_invert_highside", exp_inv_high, config_invert_highside);
    compare_value("config_invert_lowside", exp_inv_low, config_invert_lowside);
    compare_value("cos_table", exp_cos, cos_table);
    // Record fields are only defined once the slot holds a committed move
    if (busy[read_index]) begin
      compare_value("dir", exp_dir[read_index], dir);
      compare_value("move_duration", exp_duration[read_index], move_duration);
      compare_value("increment", exp_increment[read_index], increment);
      compare_value("incrementincrement", exp_incinc[read_index], incrementincrement);
    end
  endtask

  function automatic string test_name(input int n);
    case (n)
      0: return "reset defaults";
      1: return "configuration writes";
      2: return "cosine writes";
      3: return "move queueing";
      4: return "full buffer";
      default: return "replies";
    endcase
  endfunction

  initial begin
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_in_test = 0;
    reset_model();
  end

  always @(posedge word_received or negedge rst_n) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      apply_word(word_data_received, encoder_count);
      // Registers and the read port have settled a quarter period later
      #5;
      compare_outputs();
    end
  end

  always @(posedge test_end) begin
    tests_run++;
    if (errors_in_test == 0) begin
      $display("Test %0d %s: ok", test_num, test_name(test_num));
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d mismatches", test_num, test_name(test_num), errors_in_test);
    end
    errors_in_test = 0;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic word_received,
  output logic rst_n
);

  // 20 ns word clock
  initial begin
    word_received = 1'b0;
    forever #10 word_received = ~word_received;
  end

  // Reset held over two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge word_received);
    @(negedge word_received);
    rst_n = 1'b1;
  end

endmodule

// ==== tb_stepper_cmd.sv ====
`timescale 1ns/1ps

module tb_stepper_cmd
  import stepper_cmd_pkg::*;
();

  localparam int buf_size = 4;
  localparam int idx_w = (buf_size > 1) ? $clog2(buf_size) : 1;
  // Longest wait in words before the run is abandoned
  localparam int wait_limit = 200;

  logic                word_received;
  logic                rst_n;
  logic [63:0]         word_data_received;
  logic [63:0]         encoder_count;
  logic [63:0]         word_send_data;
  logic [idx_w-1:0]    read_index;
  logic [buf_size-1:0] slot_finished;
  logic [buf_size-1:0] slot_ready;
  logic                buffer_space;
  logic                dir;
  logic [63:0]         move_duration;
  logic [63:0]         increment;
  logic [63:0]         incrementincrement;
  logic                enable;
  logic [7:0]          clock_divisor;
  logic [2:0]          microsteps;
  logic [7:0]          current;
  logic [9:0]          config_offtime;
  logic [7:0]          config_blanktime;
  logic [9:0]          config_fastdecay_threshold;
  logic [7:0]          config_minimum_on_time;
  logic [10:0]         config_current_threshold;
  logic [7:0]          config_chargepump_period;
  logic                config_invert_highside;
  logic                config_invert_lowside;
  logic [511:0]        cos_table;
  logic                exec_paused;
  logic                test_end;
  int                  test_num;
  int                  error_count;
  int                  tests_run;
  int                  tests_failed;
  integer              seed;

  tb_clock_gen u_clock_gen (.*);

  stepper_cmd_top #(
    .MOVE_BUFFER_SIZE(buf_size)
  ) dut (.*);

  tb_checker #(
    .buf_size(buf_size),
    .idx_w(idx_w)
  ) u_checker (.*);

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  function automatic logic [63:0] random_payload(input logic [7:0] op);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    r[63:56] = op;
    return r;
  endfunction

  // One host word per clock with the execution side stepping alongside
  task automatic send_word(input logic [63:0] w);
    @(negedge word_received);
    word_data_received = w;
    encoder_count = {$random(seed), $random(seed)};
    if (!exec_paused && (slot_ready[read_index] != slot_finished[read_index])) begin
      if (($random(seed) & 1) == 0) begin
        slot_finished[read_index] = ~slot_finished[read_index];
        read_index = (read_index == idx_w'(buf_size - 1)) ? '0 : read_index + 1'b1;
      end
    end
  endtask

  // Four-word move that may first wait for a free slot
  task automatic send_move(input logic wait_space);
    int n;
    n = 0;
    while (wait_space && (&(slot_ready ^ slot_finished)) && n < wait_limit) begin
      send_word('0);
      n++;
    end
    if (wait_space && (&(slot_ready ^ slot_finished))) begin
      stop_on_timeout("a free move buffer slot");
    end
    send_word(random_payload(coordinated_step));
    repeat (3) begin
      send_word({$random(seed), $random(seed)});
    end
    // Idle word so slot_ready shows this commit before the next decision
    send_word('0);
  endtask

  task automatic drain_buffer();
    int n;
    n = 0;
    while ((slot_ready != slot_finished) && n < wait_limit) begin
      send_word('0);
      n++;
    end
    if (slot_ready != slot_finished) begin
      stop_on_timeout("the move buffer to drain");
    end
  endtask

  task automatic end_test();
    send_word('0);
    @(negedge word_received);
    test_end = 1'b1;
    @(negedge word_received);
    test_end = 1'b0;
    test_num++;
  endtask

  initial begin
    int n;
    seed = 32'h6857_1dfe;
    word_data_received = '0;
    encoder_count = '0;
    read_index = '0;
    slot_finished = '0;
    exec_paused = 1'b1;
    test_end = 1'b0;
    test_num = 0;
    n = 0;
    while ((rst_n !== 1'b1) && n < wait_limit) begin
      @(negedge word_received);
      n++;
    end
    if (rst_n !== 1'b1) begin
      stop_on_timeout("reset release");
    end

    repeat (4) send_word('0);
    end_test();

    repeat (8) begin
      send_word(random_payload(clk_divisor));
      send_word(random_payload(motor_config));
      send_word(random_payload(microstepper_config));
      send_word(random_payload(chargepump));
      send_word(random_payload(bridge_invert));
      send_word(random_payload(motor_enable));
    end
    // Opcodes 0x10 to 0x8F are all unassigned
    repeat (16) send_word(random_payload(8'h10 + ($random(seed) & 8'h7F)));
    end_test();

    repeat (24) send_word(random_payload(cosine_config));
    end_test();

    exec_paused = 1'b0;
    repeat (12) send_move(1'b1);
    drain_buffer();
    end_test();

    exec_paused = 1'b1;
    repeat (buf_size + 2) send_move(1'b0);
    repeat (3) send_word('0);
    exec_paused = 1'b0;
    drain_buffer();
    repeat (4) send_move(1'b1);
    drain_buffer();
    end_test();

    send_word(random_payload(api_version));
    send_word('0);
    repeat (4) begin
      send_move(1'b1);
      send_word(random_payload(api_version));
      send_word({$random(seed), $random(seed)} & 64'h00FF_FFFF_FFFF_FFFF);
    end
    drain_buffer();
    end_test();

    send_word('0);
    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
